/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_harness -f src.f -o tb_harness_sim &&
    ./obj_dir/tb_harness_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
    echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* source/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter import harness_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  bus_req_t host_req_i,
    output bus_rsp_t host_rsp_o,
    input  bus_req_t core_req_i,
    output bus_rsp_t core_rsp_o,
    output bus_req_t mem_req_o,
    input  bus_rsp_t mem_rsp_i
);

    logic busy_q;       // Grant locked until memory ack
    logic grant_core_q;
    logic last_core_q;  // Side served most recently
    logic host_want;
    logic core_want;
    logic pick_core;

    assign host_want = host_req_i.cyc && host_req_i.stb;
    assign core_want = core_req_i.cyc && core_req_i.stb;

    // On contention the side not served last wins
    assign pick_core = (host_want && core_want) ? !last_core_q : core_want;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            grant_core_q <= 1'b0;
            last_core_q  <= 1'b0;
        end else if (busy_q) begin
            if (mem_rsp_i.ack) begin
                busy_q      <= 1'b0;
                last_core_q <= grant_core_q;
            end
        end else if (host_want || core_want) begin
            busy_q       <= 1'b1;
            grant_core_q <= pick_core;
        end
    end

    always_comb begin
        mem_req_o = '0;
        if (busy_q) mem_req_o = grant_core_q ? core_req_i : host_req_i;
    end

    // Read data fans out, ack only to the granted side
    assign host_rsp_o = '{ack: mem_rsp_i.ack && busy_q && !grant_core_q, data: mem_rsp_i.data};
    assign core_rsp_o = '{ack: mem_rsp_i.ack && busy_q && grant_core_q, data: mem_rsp_i.data};

    // Granted side keeps its request up until the ack arrives
    a_grant_held: assert property (
        @(posedge clk) disable iff (rst_i)
        busy_q |-> (grant_core_q ? core_want : host_want)
    );

endmodule

/* source/cmd_parser.sv */
`timescale 1ns/100ps

module cmd_parser import harness_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic [7:0] host_data_i,
    input  logic       host_valid_i,
    output logic       host_ready_o,
    output bus_req_t   bus_req_o,
    input  logic       bus_ack_i,
    input  logic       rsp_done_i,
    output logic [7:0] status_o,
    output logic       status_valid_o,
    output logic       core_release_o,
    output logic       core_hold_o
);

    typedef enum logic [2:0] {
        S_IDLE,   // One cycle out of reset, keeps ready low
        S_OPCODE,
        S_ADDR,
        S_DATA,
        S_BUS,    // Request held until ack
        S_WAIT    // Response bytes still going out
    } state_t;

    state_t      state_q;
    logic [1:0]  byte_cnt_q;
    logic        is_write_q;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic        byte_take;

    assign host_ready_o = (state_q == S_OPCODE) || (state_q == S_ADDR) || (state_q == S_DATA);
    assign byte_take    = host_ready_o && host_valid_i;

    always_ff @(posedge clk) begin
        status_valid_o <= 1'b0;
        core_release_o <= 1'b0;
        core_hold_o    <= 1'b0;
        if (rst_i) begin
            state_q    <= S_IDLE;
            byte_cnt_q <= '0;
            is_write_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: state_q <= S_OPCODE;
                S_OPCODE: if (byte_take) begin
                    case (host_data_i)
                        OP_WRITE: begin
                            is_write_q <= 1'b1;
                            state_q    <= S_ADDR;
                        end
                        OP_READ: begin
                            is_write_q <= 1'b0;
                            state_q    <= S_ADDR;
                        end
                        OP_RELEASE: begin
                            core_release_o <= 1'b1;
                            status_o       <= RSP_OK;
                            status_valid_o <= 1'b1;
                            state_q        <= S_WAIT;
                        end
                        OP_HOLD: begin
                            core_hold_o    <= 1'b1;
                            status_o       <= RSP_OK;
                            status_valid_o <= 1'b1;
                            state_q        <= S_WAIT;
                        end
                        default: begin // Only the opcode byte is consumed
                            status_o       <= RSP_BAD;
                            status_valid_o <= 1'b1;
                            state_q        <= S_WAIT;
                        end
                    endcase
                end
                S_ADDR: if (byte_take) begin
                    byte_cnt_q <= byte_cnt_q + 2'd1; // Wraps back to zero after byte 3
                    if (byte_cnt_q == 2'd3) begin
                        state_q <= is_write_q ? S_DATA : S_BUS;
                    end
                end
                S_DATA: if (byte_take) begin
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                    if (byte_cnt_q == 2'd3) begin
                        state_q <= S_BUS;
                    end
                end
                S_BUS: if (bus_ack_i) begin
                    // Read data goes to the builder straight from the bus reply
                    if (is_write_q) begin
                        status_o       <= RSP_OK;
                        status_valid_o <= 1'b1;
                    end
                    state_q <= S_WAIT;
                end
                S_WAIT: if (rsp_done_i) state_q <= S_OPCODE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Address and data arrive MSB first
    always_ff @(posedge clk) begin
        if (byte_take && state_q == S_ADDR) addr_q <= {addr_q[23:0], host_data_i};
        if (byte_take && state_q == S_DATA) data_q <= {data_q[23:0], host_data_i};
    end

    always_comb begin
        bus_req_o.cyc  = (state_q == S_BUS);
        bus_req_o.stb  = (state_q == S_BUS);
        bus_req_o.we   = is_write_q;
        bus_req_o.addr = addr_q;
        bus_req_o.data = data_q;
    end

    // Wishbone classic: a pending request must not move
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (bus_req_o.stb && !bus_ack_i) |=> $stable(bus_req_o)
    );

endmodule

/* source/harness_pkg.sv */
package harness_pkg;

    // Wishbone classic request as seen by the shared memory
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;
        logic [31:0] data; // Write data
    } bus_req_t;

    // Reply path back to the requester
    typedef struct packed {
        logic        ack;
        logic [31:0] data; // Read data, valid with ack
    } bus_rsp_t;

    // Host command opcodes
    localparam logic [7:0] OP_WRITE   = 8'h01; // + 4 addr bytes + 4 data bytes
    localparam logic [7:0] OP_READ    = 8'h02; // + 4 addr bytes
    localparam logic [7:0] OP_RELEASE = 8'h03;
    localparam logic [7:0] OP_HOLD    = 8'h04;

    // Single byte answers
    localparam logic [7:0] RSP_OK  = 8'hAA;
    localparam logic [7:0] RSP_BAD = 8'hEE;

    // System reset stretch after rst_i falls
    localparam int RESET_CYCLES   = 20;
    localparam int RESET_CNT_BITS = $clog2(RESET_CYCLES + 1);

    // Word memory sizing, index taken from addr[11:2]
    localparam int MEM_WORDS     = 1024;
    localparam int MEM_ADDR_BITS = 10;

endpackage

/* source/harness_top.sv */
`timescale 1ns/100ps

module harness_top import harness_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic [7:0]  host_data_i,
    input  logic        host_valid_i,
    output logic        host_ready_o,
    output logic [7:0]  rsp_data_o,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    input  logic        core_cyc_i,
    input  logic        core_stb_i,
    input  logic        core_we_i,
    input  logic [31:0] core_addr_i,
    input  logic [31:0] core_data_i,
    output logic [31:0] core_data_o,
    output logic        core_ack_o,
    output logic        core_rst_o
);

    logic       sys_rst;
    logic       core_release;
    logic       core_hold;
    logic [7:0] status;
    logic       status_valid;
    logic       rsp_done;
    bus_req_t   host_req;
    bus_rsp_t   host_rsp;
    bus_req_t   core_req;
    bus_rsp_t   core_rsp;
    bus_req_t   mem_req;
    bus_rsp_t   mem_rsp;

    reset_sequencer reset_sequencer_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .core_release_i (core_release),
        .core_hold_i    (core_hold),
        .sys_rst_o      (sys_rst),
        .core_rst_o     (core_rst_o)
    );

    cmd_parser cmd_parser_i (
        .clk            (clk),
        .rst_i          (sys_rst),
        .host_data_i    (host_data_i),
        .host_valid_i   (host_valid_i),
        .host_ready_o   (host_ready_o),
        .bus_req_o      (host_req),
        .bus_ack_i      (host_rsp.ack),
        .rsp_done_i     (rsp_done),
        .status_o       (status),
        .status_valid_o (status_valid),
        .core_release_o (core_release),
        .core_hold_o    (core_hold)
    );

    // Core held in reset cannot reach the memory
    assign core_req = '{cyc:  core_cyc_i && !core_rst_o,
                        stb:  core_stb_i,
                        we:   core_we_i,
                        addr: core_addr_i,
                        data: core_data_i};

    bus_arbiter bus_arbiter_i (
        .clk        (clk),
        .rst_i      (sys_rst),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    wb_memory wb_memory_i (
        .clk   (clk),
        .rst_i (sys_rst),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    resp_builder resp_builder_i (
        .clk            (clk),
        .rst_i          (sys_rst),
        .read_rsp_i     (host_rsp),
        .read_pending_i (host_req.cyc && !host_req.we),
        .status_i       (status),
        .status_valid_i (status_valid),
        .rsp_data_o     (rsp_data_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .done_o         (rsp_done)
    );

    assign core_data_o = core_rsp.data;
    assign core_ack_o  = core_rsp.ack;

endmodule

/* source/reset_sequencer.sv */
`timescale 1ns/100ps

module reset_sequencer import harness_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    input  logic core_release_i, // One-cycle pulse from the parser
    input  logic core_hold_i,    // One-cycle pulse from the parser
    output logic sys_rst_o,
    output logic core_rst_o
);

    logic [RESET_CNT_BITS-1:0] rst_cnt_q;
    logic                      core_rst_q;

    // Counter reloads while rst_i is high, then runs down to zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rst_cnt_q <= RESET_CNT_BITS'(RESET_CYCLES);
        end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
        end
    end

    assign sys_rst_o = (rst_cnt_q != '0);

    // Core stays parked until the host explicitly lets it run
    always_ff @(posedge clk) begin
        if (rst_i || sys_rst_o) begin
            core_rst_q <= 1'b1;
        end else if (core_release_i) begin
            core_rst_q <= 1'b0;
        end else if (core_hold_i) begin
            core_rst_q <= 1'b1;
        end
    end

    assign core_rst_o = core_rst_q;

    // Parser issues at most one control action per command
    a_no_release_and_hold: assert property (
        @(posedge clk) disable iff (rst_i)
        !(core_release_i && core_hold_i)
    );

endmodule

/* source/resp_builder.sv */
`timescale 1ns/100ps

module resp_builder import harness_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  bus_rsp_t   read_rsp_i,
    input  logic       read_pending_i,  // Host command in flight is a read
    input  logic [7:0] status_i,
    input  logic       status_valid_i,
    output logic [7:0] rsp_data_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output logic       done_o
);

    logic [31:0] shift_q;
    logic [2:0]  left_q;    // Bytes still to send
    logic        read_load;
    logic        byte_out;

    assign read_load = read_rsp_i.ack && read_pending_i;
    assign byte_out  = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk) begin
        done_o <= 1'b0;
        if (rst_i) begin
            left_q <= '0;
        end else if (read_load) begin
            left_q <= 3'd4;
        end else if (status_valid_i) begin
            left_q <= 3'd1;
        end else if (byte_out) begin
            left_q <= left_q - 3'd1;
            done_o <= (left_q == 3'd1); // Last byte accepted
        end
    end

    // Payload, MSB first out of the top byte
    always_ff @(posedge clk) begin
        if (read_load) begin
            shift_q <= read_rsp_i.data;
        end else if (status_valid_i) begin
            shift_q <= {status_i, 24'h0};
        end else if (byte_out) begin
            shift_q <= {shift_q[23:0], 8'h0};
        end
    end

    assign rsp_data_o  = shift_q[31:24];
    assign rsp_valid_o = (left_q != '0);

    // Parser waits for done, so nothing new may arrive mid response
    a_load_when_empty: assert property (
        @(posedge clk) disable iff (rst_i)
        (read_load || status_valid_i) |-> (left_q == '0)
    );

endmodule

/* source/wb_memory.sv */
`timescale 1ns/100ps

module wb_memory import harness_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    logic [31:0]              mem [MEM_WORDS];
    logic [MEM_ADDR_BITS-1:0] word_idx;
    logic                     access;
    logic                     ack_q;
    logic [31:0]              rdata_q;

    // Upper address bits ignored, so the array aliases every 4 KiB
    assign word_idx = req_i.addr[MEM_ADDR_BITS+1:2];

    // Held stb would ack again without the ack_q term
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && req_i.we) begin
            mem[word_idx] <= req_i.data;
        end
        if (access) begin
            rdata_q <= mem[word_idx]; // Valid alongside ack
        end
    end

    assign rsp_o = '{ack: ack_q, data: rdata_q};

endmodule

/* src.f */
source/harness_pkg.sv
source/reset_sequencer.sv
source/cmd_parser.sv
source/bus_arbiter.sv
source/wb_memory.sv
source/resp_builder.sv
source/harness_top.sv
tests/tb_checker.sv
tests/tb_harness.sv

/* tests/harness_tests.txt */
# name  opcode  address  data  expected   (all hex; a read expects the word, others one byte)
# opcodes 01-04 or unknown go over the host link; 81 core write, 82 core read, 83 core probe, 90 contention
write_a          01 00000010 11223344 000000aa
write_b          01 00000014 deadbeef 000000aa
read_a           02 00000010 00000000 11223344
read_b           02 00000014 00000000 deadbeef
write_alias      01 00001010 cafef00d 000000aa
read_alias_base  02 00000010 00000000 cafef00d
read_alias_high  02 00003010 00000000 cafef00d
bad_opcode       7f 00000000 00000000 000000ee
read_after_bad   02 00000014 00000000 deadbeef
core_held        83 00000010 00000000 00000000
release          03 00000000 00000000 000000aa
core_read_host   82 00000010 00000000 cafef00d
core_write       81 00000020 0badc0de 00000000
host_read_core   02 00000020 00000000 0badc0de
hold             04 00000000 00000000 000000aa
core_held_again  83 00000020 00000000 00000000
release_again    03 00000000 00000000 000000aa
contend_a        90 00000100 a5a5a5a5 a5a5a5a5
contend_b        90 00000104 5a5a5a5a 5a5a5a5a
contend_c        90 00000ffc 01020304 01020304

/* tests/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker import harness_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       host_ready_i,
    input  logic [7:0] rsp_data_i,
    input  logic       rsp_valid_i,
    input  logic       rsp_ready_i,
    input  logic       core_ack_i,
    input  logic       core_rst_i
);

    logic [7:0]  rx_buf [1024]; // Accepted response bytes, in arrival order
    int          rx_wr = 0;
    int          rx_rd = 0;
    logic [31:0] model [MEM_WORDS]; // Words written by core traffic
    int          since_rst = 0;
    logic        reset_bad = 1'b0;
    logic        stalled = 1'b0;
    logic [7:0]  stalled_data = 8'h00;
    int          hold_viol = 0;
    int          hold_seen = 0;
    string       cur_name = "";
    int          test_err = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          err_cnt = 0;

    always @(posedge clk) begin
        if (!rst_i && rsp_valid_i && rsp_ready_i) begin
            rx_buf[rx_wr[9:0]] <= rsp_data_i;
            rx_wr              <= rx_wr + 1;
        end
        // A stalled byte has to stay put until it is taken
        if (stalled && (!rsp_valid_i || rsp_data_i != stalled_data)) begin
            hold_viol <= hold_viol + 1;
        end
        stalled      <= !rst_i && rsp_valid_i && !rsp_ready_i;
        stalled_data <= rsp_data_i;
    end

    // Outputs keep reset values for RESET_CYCLES edges after rst_i falls
    always @(posedge clk) begin
        if (rst_i) begin
            since_rst <= 0;
        end else if (since_rst < RESET_CYCLES) begin
            since_rst <= since_rst + 1;
            if (host_ready_i || rsp_valid_i || core_ack_i || !core_rst_i) reset_bad <= 1'b1;
        end
    end

    task automatic fail_plain(input string msg);
        $display("FAILURE in %s: %s", cur_name, msg);
        test_err++;
        err_cnt++;
    endtask

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", cur_name, exp, act);
            test_err++;
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_name = name;
        test_err = 0;
        if (rx_wr != rx_rd) begin
            fail_plain("response bytes arrived that no command asked for");
            rx_rd = rx_wr;
        end
    endtask

    // Gathers n bytes, first byte most significant
    task automatic expect_rsp(input int n, input logic [31:0] exp);
        logic [31:0] word;
        word = 32'h0;
        while (rx_wr - rx_rd < n) @(negedge clk);
        for (int k = 0; k < n; k++) begin
            word = {word[23:0], rx_buf[rx_rd[9:0]]};
            rx_rd++;
        end
        check_value(exp, word);
    endtask

    // Word index is address bits 11..2
    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        model[addr[11:2]] = data;
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        return model[addr[11:2]];
    endfunction

    task automatic end_test();
        if (hold_viol != hold_seen) begin
            fail_plain("a response byte changed or vanished while it was stalled");
            hold_seen = hold_viol;
        end
        if (test_err == 0) begin
            pass_cnt++;
            $display("PASS %s", cur_name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", cur_name, test_err);
        end
    endtask

    task automatic finish_reset();
        start_test("reset");
        if (reset_bad) fail_plain("outputs left their reset values too early after rst_i fell");
        if (!core_rst_i) fail_plain("core reset is not held after the system reset");
        end_test();
    endtask

    task automatic print_counts();
        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    endtask

endmodule

/* tests/tb_harness.sv */
`timescale 1ns/100ps

// 8 ns bench clock
module tb_clock (
    output logic clk_o
);
    initial clk_o = 1'b0;
    always #4 clk_o = ~clk_o; // Half period
endmodule

module tb_harness import harness_pkg::*; ();

    logic        clk;
    logic        rst;
    logic [7:0]  host_data;
    logic        host_valid;
    logic        host_ready;
    logic [7:0]  rsp_data;
    logic        rsp_valid;
    logic        rsp_ready = 1'b0;
    logic [31:0] ready_rng = 32'h23c7891b;
    logic        core_cyc;
    logic        core_stb;
    logic        core_we;
    logic [31:0] core_addr;
    logic [31:0] core_wdata;
    logic [31:0] core_rdata;
    logic        core_ack;
    logic        core_rst;
    logic [31:0] core_rng;
    string       t_name [$];
    logic [7:0]  t_op [$];
    logic [31:0] t_addr [$];
    logic [31:0] t_data [$];
    logic [31:0] t_exp [$];
    int          n_tests = 0;
    int          watchdog_ns;
    logic        tests_loaded = 1'b0;
    logic        load_failed = 1'b0;

    tb_clock tb_clock_i (.clk_o(clk));

    harness_top harness_top_i (
        .clk          (clk),
        .rst_i        (rst),
        .host_data_i  (host_data),
        .host_valid_i (host_valid),
        .host_ready_o (host_ready),
        .rsp_data_o   (rsp_data),
        .rsp_valid_o  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .core_cyc_i   (core_cyc),
        .core_stb_i   (core_stb),
        .core_we_i    (core_we),
        .core_addr_i  (core_addr),
        .core_data_i  (core_wdata),
        .core_data_o  (core_rdata),
        .core_ack_o   (core_ack),
        .core_rst_o   (core_rst)
    );

    tb_checker checker_i (
        .clk          (clk),
        .rst_i        (rst),
        .host_ready_i (host_ready),
        .rsp_data_i   (rsp_data),
        .rsp_valid_i  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .core_ack_i   (core_ack),
        .core_rst_i   (core_rst)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Host takes a byte about three cycles in four
    always @(posedge clk) begin
        ready_rng <= xorshift32(ready_rng);
        rsp_ready <= (ready_rng[1:0] != 2'b00);
    end

    task automatic load_tests();
        int          fd;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        fd = $fopen("tests/harness_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/harness_tests.txt");
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%s %h %h %h %h", name, op, addr, data, exp) == 5) begin
                    t_name.push_back(name);
                    t_op.push_back(op);
                    t_addr.push_back(addr);
                    t_data.push_back(data);
                    t_exp.push_back(exp);
                end
            end
            $fclose(fd);
        end
        n_tests = t_name.size();
        if (n_tests == 0) begin
            $display("No tests were found in tests/harness_tests.txt");
            load_failed = 1'b1;
        end
        tests_loaded = 1'b1;
    endtask

    // Byte moves on the edge after a cycle with ready seen high
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        host_data  <= b;
        host_valid <= 1'b1;
        do @(negedge clk); while (!host_ready);
        @(posedge clk);
        host_valid <= 1'b0;
    endtask

    task automatic host_cmd(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        send_byte(op);
        if (op == OP_WRITE || op == OP_READ) begin
            for (int k = 3; k >= 0; k--) begin
                send_byte(addr[8*k +: 8]);
            end
        end
        if (op == OP_WRITE) begin
            for (int k = 3; k >= 0; k--) begin
                send_byte(data[8*k +: 8]);
            end
        end
        checker_i.expect_rsp((op == OP_READ) ? 4 : 1, exp);
    endtask

    // Wishbone classic cycle, held until ack
    task automatic core_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        core_cyc   <= 1'b1;
        core_stb   <= 1'b1;
        core_we    <= we;
        core_addr  <= addr;
        core_wdata <= wdata;
        do @(negedge clk); while (!core_ack);
        rdata = core_rdata;
        @(posedge clk);
        core_cyc <= 1'b0;
        core_stb <= 1'b0;
        core_we  <= 1'b0;
    endtask

    // Request while the core sits in reset must never be acked
    task automatic core_probe(input logic [31:0] addr);
        logic acked;
        acked = 1'b0;
        if (!core_rst) checker_i.fail_plain("core is not held in reset");
        @(posedge clk);
        core_cyc  <= 1'b1;
        core_stb  <= 1'b1;
        core_we   <= 1'b0;
        core_addr <= addr;
        repeat (32) begin
            @(negedge clk);
            if (core_ack) acked = 1'b1;
        end
        @(posedge clk);
        core_cyc <= 1'b0;
        core_stb <= 1'b0;
        if (acked) checker_i.fail_plain("core request was acked while the core was in reset");
    endtask

    // Random write/read pairs in words 512..527, clear of the host words
    task automatic core_traffic(input int n);
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        for (int j = 0; j < n; j++) begin
            core_rng = xorshift32(core_rng);
            a = 32'h800 + {26'h0, core_rng[3:0], 2'b00};
            core_rng = xorshift32(core_rng);
            d = core_rng;
            core_access(1'b1, a, d, r);
            checker_i.model_write(a, d);
            core_access(1'b0, a, 32'h0, r);
            checker_i.check_value(checker_i.model_read(a), r);
        end
    endtask

    task automatic run_test(input int i);
        logic [31:0] rdata;
        @(negedge clk);
        checker_i.start_test(t_name[i]);
        case (t_op[i])
            8'h81, 8'h82: begin
                if (core_rst) begin
                    checker_i.fail_plain("core is still held in reset");
                end else begin
                    core_access(t_op[i] == 8'h81, t_addr[i], t_data[i], rdata);
                    if (t_op[i] == 8'h82) checker_i.check_value(t_exp[i], rdata);
                end
            end
            8'h83: core_probe(t_addr[i]);
            8'h90: begin
                fork
                    begin
                        host_cmd(OP_WRITE, t_addr[i], t_data[i], {24'h0, RSP_OK});
                        host_cmd(OP_READ, t_addr[i], 32'h0, t_exp[i]);
                    end
                    core_traffic(8);
                join
            end
            default: host_cmd(t_op[i], t_addr[i], t_data[i], t_exp[i]);
        endcase
        checker_i.end_test();
    endtask

    initial begin
        rst        = 1'b1;
        host_valid = 1'b0;
        host_data  = 8'h00;
        core_cyc   = 1'b0;
        core_stb   = 1'b0;
        core_we    = 1'b0;
        core_addr  = 32'h0;
        core_wdata = 32'h0;
        core_rng   = 32'h23c7891b;
        load_tests();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        do @(negedge clk); while (!host_ready);
        checker_i.finish_reset();
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        repeat (8) @(posedge clk);
        checker_i.print_counts();
        if (load_failed || checker_i.fail_cnt != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

    // Budget of 2 us per test on top of the reset phase
    initial begin
        wait (tests_loaded);
        watchdog_ns = n_tests * 2000 + (16 + RESET_CYCLES + 8) * 8;
        #(watchdog_ns);
        $display("Watchdog timeout after %0d ns, the DUT stopped answering", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule
